// File: Bender.yml
package:
  name: emu_harness

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/emu_pkg.sv
      - hw/emu_clock_ctrl.sv
      - hw/emu_ram_scan.sv
      - hw/emu_target_core.sv
      - hw/emu_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_emu_system.sv

// File: hw/emu_clock_ctrl.sv
`timescale 1ns/10ps

module emu_clock_ctrl (
    input  logic host_clk,
    input  logic rst_n,
    input  logic run_mode,
    input  logic scan_mode,
    output logic step,
    output logic scan_en,
    output logic idle
);

    emu_pkg::emu_state_t state;
    emu_pkg::emu_state_t state_nxt;

    // scan mode has priority, the target must not step while its chain moves.
    always_comb begin
        if (scan_mode) begin
            state_nxt = emu_pkg::ST_SCAN;
        end else if (run_mode) begin
            state_nxt = emu_pkg::ST_RUN;
        end else begin
            state_nxt = emu_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            state <= emu_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // outputs come straight from the state register, one cycle after the mode.
    assign step    = (state == emu_pkg::ST_RUN);
    assign scan_en = (state == emu_pkg::ST_SCAN);
    assign idle    = (state == emu_pkg::ST_IDLE);

    property p_step_scan_exclusive;
        @(posedge host_clk) disable iff (!rst_n)
            !(step && scan_en);
    endproperty

    a_step_scan_exclusive : assert property (p_step_scan_exclusive)
        else $error("step and scan_en high together");

    property p_idle_decode;
        @(posedge host_clk) disable iff (!rst_n)
            idle == !(step || scan_en);
    endproperty

    a_idle_decode : assert property (p_idle_decode)
        else $error("idle does not match step and scan_en");

    // a scan request is honoured on the next cycle even while running.
    property p_scan_latency;
        @(posedge host_clk) disable iff (!rst_n)
            scan_mode |=> scan_en && !step;
    endproperty

    a_scan_latency : assert property (p_scan_latency)
        else $error("scan_mode not followed by scan_en");

endmodule

// File: hw/emu_pkg.sv
`include "emu_consts.svh"

package emu_pkg;

    // accumulator values, memory words and scan words.
    typedef logic [`EMU_DATA_W-1:0] word_t;

    // program counter and ram scan pointer.
    typedef logic [`EMU_ADDR_W-1:0] addr_t;

    // harness control state, scan wins over run.
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_SCAN = 2'd2
    } emu_state_t;

endpackage

// File: hw/emu_ram_scan.sv
`timescale 1ns/10ps

`include "emu_consts.svh"

module emu_ram_scan (
    input  logic           host_clk,
    input  logic           rst_n,
    input  logic           scan_en,
    input  logic           ram_scan_reset,
    input  logic           ram_scan,
    input  logic           ram_dir,
    input  emu_pkg::word_t ram_sdi,
    output emu_pkg::word_t ram_sdo,
    input  emu_pkg::addr_t rd_addr,
    output emu_pkg::word_t rd_data
);

    emu_pkg::word_t mem [0:`EMU_MEM_DEPTH-1];
    emu_pkg::addr_t ram_ptr;
    emu_pkg::addr_t ram_ptr_inc;
    logic           ptr_clr;
    logic           scan_step;
    logic           scan_wr;
    logic           scan_rd;

    // the pointer wraps by overflow, so the depth must fill the address space.
    generate
        if ((1 << `EMU_ADDR_W) != `EMU_MEM_DEPTH) begin : g_depth_check
            $error("memory depth does not match the address width");
        end
    endgenerate

    // pointer reset wins over a scan strobe on the same edge.
    assign ptr_clr     = scan_en && ram_scan_reset;
    assign scan_step   = scan_en && !ram_scan_reset && ram_scan;
    assign scan_wr     = scan_step && ram_dir;
    assign scan_rd     = scan_step && !ram_dir;
    assign ram_ptr_inc = ram_ptr + emu_pkg::addr_t'(1);

    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            ram_ptr <= '0;
        end else if (ptr_clr) begin
            ram_ptr <= '0;
        end else if (scan_step) begin
            ram_ptr <= ram_ptr_inc;
        end
    end

    always_ff @(posedge host_clk) begin
        if (scan_wr) begin
            mem[ram_ptr] <= ram_sdi;
        end
    end

    // read data holds until the next scan read.
    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            ram_sdo <= '0;
        end else if (scan_rd) begin
            ram_sdo <= mem[ram_ptr];
        end
    end

    // the target fetches combinationally so a step finishes in one edge.
    assign rd_data = mem[rd_addr];

    // outside scan mode neither the pointer nor the word under it may move.
    property p_no_write_outside_scan;
        @(posedge host_clk) disable iff (!rst_n)
            !scan_en |=> $stable(ram_ptr) && (mem[ram_ptr] === $past(mem[ram_ptr]));
    endproperty

    a_no_write_outside_scan : assert property (p_no_write_outside_scan)
        else $error("ram scan state changed while scan_en low");

endmodule

// File: hw/emu_system.sv
`timescale 1ns/10ps

module emu_system (
    input  logic           host_clk,
    input  logic           rst_n,
    input  logic           run_mode,
    input  logic           scan_mode,
    output logic           idle,
    output logic           target_step,
    input  logic           ff_scan,
    input  logic           ff_dir,
    input  emu_pkg::word_t ff_sdi,
    output emu_pkg::word_t ff_sdo,
    input  logic           ram_scan_reset,
    input  logic           ram_scan,
    input  logic           ram_dir,
    input  emu_pkg::word_t ram_sdi,
    output emu_pkg::word_t ram_sdo
);

    logic           step;
    logic           scan_en;
    emu_pkg::word_t ff_di;
    emu_pkg::addr_t mem_addr;
    emu_pkg::word_t mem_data;

    emu_clock_ctrl clock_ctrl_i (
        .host_clk  (host_clk),
        .rst_n     (rst_n),
        .run_mode  (run_mode),
        .scan_mode (scan_mode),
        .step      (step),
        .scan_en   (scan_en),
        .idle      (idle)
    );

    // ff_dir low feeds the chain output back in, rotating it in place.
    assign ff_di = ff_dir ? ff_sdi : ff_sdo;

    emu_target_core target_core_i (
        .host_clk (host_clk),
        .rst_n    (rst_n),
        .step     (step),
        .scan_en  (scan_en),
        .ff_scan  (ff_scan),
        .ff_di    (ff_di),
        .ff_do    (ff_sdo),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    emu_ram_scan ram_scan_i (
        .host_clk       (host_clk),
        .rst_n          (rst_n),
        .scan_en        (scan_en),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .ram_sdo        (ram_sdo),
        .rd_addr        (mem_addr),
        .rd_data        (mem_data)
    );

    // one pulse per target step.
    assign target_step = step;

endmodule

// File: hw/emu_target_core.sv
`timescale 1ns/10ps

`include "emu_consts.svh"

module emu_target_core (
    input  logic           host_clk,
    input  logic           rst_n,
    input  logic           step,
    input  logic           scan_en,
    input  logic           ff_scan,
    input  emu_pkg::word_t ff_di,
    output emu_pkg::word_t ff_do,
    output emu_pkg::addr_t mem_addr,
    input  emu_pkg::word_t mem_data
);

    localparam int HI_W = `EMU_DATA_W - `EMU_ADDR_W;

    emu_pkg::word_t  acc;
    emu_pkg::addr_t  pc;
    logic [HI_W-1:0] pc_word_hi;
    emu_pkg::word_t  chain [0:`EMU_CHAIN_LEN-1];
    emu_pkg::word_t  acc_sum;
    emu_pkg::addr_t  pc_inc;
    logic            shift;

    // the shift below is written for exactly two chain words.
    generate
        if (`EMU_CHAIN_LEN != 2) begin : g_chain_len_check
            $error("ff scan chain expects two words");
        end
    endgenerate

    // word 0 of the chain is shifted out first.
    assign chain[0] = acc;
    assign chain[1] = {pc_word_hi, pc};

    assign shift   = scan_en && ff_scan;
    assign acc_sum = acc + mem_data;
    assign pc_inc  = pc + emu_pkg::addr_t'(1);

    // pc_word_hi carries the upper bits of word 1 while the chain rotates,
    // so a loopback scan returns every bit. a step clears it again.
    always_ff @(posedge host_clk) begin
        if (!rst_n) begin
            acc        <= '0;
            pc         <= '0;
            pc_word_hi <= '0;
        end else if (shift) begin
            acc              <= chain[1];
            {pc_word_hi, pc} <= ff_di;
        end else if (step) begin
            acc        <= acc_sum;
            pc         <= pc_inc;
            pc_word_hi <= '0;
        end
    end

    assign ff_do    = chain[0];
    assign mem_addr = pc;

    // the control stage keeps step and shift apart.
    property p_no_step_during_shift;
        @(posedge host_clk) disable iff (!rst_n)
            shift |-> !step;
    endproperty

    a_no_step_during_shift : assert property (p_no_step_during_shift)
        else $error("target step during ff scan shift");

endmodule

// File: include/emu_consts.svh
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

// width of a target word and of one scan word.
`define EMU_DATA_W 64

// number of words in the target memory.
`define EMU_MEM_DEPTH 16

// program counter and ram scan pointer width, log2 of the depth.
`define EMU_ADDR_W 4

// words in the ff scan chain: accumulator, then program counter.
`define EMU_CHAIN_LEN 2

`endif

// File: tb.f
+incdir+include
hw/emu_pkg.sv
hw/emu_clock_ctrl.sv
hw/emu_ram_scan.sv
hw/emu_target_core.sv
hw/emu_system.sv
testbench/tb_emu_system.sv

// File: testbench/tb_emu_system.sv
`timescale 1ns/10ps

`include "emu_consts.svh"

module tb_emu_system;

    localparam int NUM_TESTS = 9;
    localparam logic [3:0] K_RESET = 4'd0;
    localparam logic [3:0] K_RAM   = 4'd1;
    localparam logic [3:0] K_RUN   = 4'd2;
    localparam logic [3:0] K_LOOP  = 4'd3;
    localparam logic [3:0] K_LOAD  = 4'd4;
    localparam logic [3:0] K_PRIO  = 4'd5;

    typedef struct packed {
        logic [3:0]     kind;
        logic [7:0]     steps;
        emu_pkg::word_t acc;
        emu_pkg::addr_t pc;
    } test_row_t;

    logic           host_clk;
    logic           rst_n;
    logic           run_mode;
    logic           scan_mode;
    logic           idle;
    logic           target_step;
    logic           ff_scan;
    logic           ff_dir;
    emu_pkg::word_t ff_sdi;
    emu_pkg::word_t ff_sdo;
    logic           ram_scan_reset;
    logic           ram_scan;
    logic           ram_dir;
    emu_pkg::word_t ram_sdi;
    emu_pkg::word_t ram_sdo;

    // reference model of the target.
    emu_pkg::word_t mem_m [0:`EMU_MEM_DEPTH-1];
    emu_pkg::word_t acc_m;
    emu_pkg::addr_t pc_m;

    logic [31:0]         lfsr;
    int                  n_checks;
    int                  n_errors;
    int                  errs_before;
    int                  checks_before;
    test_row_t           row;
    emu_pkg::emu_state_t st;

    emu_system dut_i (
        .host_clk       (host_clk),
        .rst_n          (rst_n),
        .run_mode       (run_mode),
        .scan_mode      (scan_mode),
        .idle           (idle),
        .target_step    (target_step),
        .ff_scan        (ff_scan),
        .ff_dir         (ff_dir),
        .ff_sdi         (ff_sdi),
        .ff_sdo         (ff_sdo),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .ram_sdo        (ram_sdo)
    );

    initial begin
        host_clk = 1'b0;
        forever #20 host_clk = ~host_clk;
    end

    function automatic test_row_t get_row(input int idx);
        test_row_t r;
        r = '{K_RESET, 8'd0, '0, '0};
        case (idx)
            1: r = '{K_RAM, 8'd16, '0, '0};
            2: r = '{K_RUN, 8'd5, '0, '0};
            3: r = '{K_LOOP, 8'd0, '0, '0};
            4: r = '{K_RUN, 8'd13, '0, '0};
            5: r = '{K_LOOP, 8'd0, '0, '0};
            6: r = '{K_LOAD, 8'd7, 64'h0123_4567_89ab_cdef, 4'd11};
            7: r = '{K_LOAD, 8'd20, 64'hffff_ffff_ffff_fff0, 4'd3};
            8: r = '{K_PRIO, 8'd4, '0, '0};
            default: r = '{K_RESET, 8'd0, '0, '0};
        endcase
        return r;
    endfunction

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            K_RESET: return "reset";
            K_RAM:   return "ram";
            K_RUN:   return "run";
            K_LOOP:  return "loop";
            K_LOAD:  return "load";
            default: return "prio";
        endcase
    endfunction

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic emu_pkg::word_t random_word();
        emu_pkg::word_t w;
        w = '0;
        for (int b = 0; b < `EMU_DATA_W; b++) begin
            w = {w[`EMU_DATA_W-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    task automatic check_word(input string name, input emu_pkg::word_t exp,
                              input emu_pkg::word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input emu_pkg::addr_t exp,
                              input emu_pkg::addr_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_pulses(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("[FAIL] %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // all tasks below start and end on a falling edge.
    task automatic enter_scan();
        run_mode  = 1'b0;
        scan_mode = 1'b1;
        @(negedge host_clk);
    endtask

    task automatic leave_scan();
        scan_mode = 1'b0;
        @(negedge host_clk);
    endtask

    task automatic shift_word(input emu_pkg::word_t din, output emu_pkg::word_t dout);
        dout    = ff_sdo;
        ff_sdi  = din;
        ff_scan = 1'b1;
        @(negedge host_clk);
        ff_scan = 1'b0;
    endtask

    task automatic scan_chain(input logic dir, input emu_pkg::word_t in0,
                              input emu_pkg::word_t in1,
                              output emu_pkg::word_t out0, output emu_pkg::word_t out1);
        ff_dir = dir;
        shift_word(in0, out0);
        shift_word(in1, out1);
        ff_dir = 1'b1;
    endtask

    // scan the chain out and put the expected values back in.
    task automatic check_chain();
        emu_pkg::word_t w0;
        emu_pkg::word_t w1;
        scan_chain(1'b1, acc_m, emu_pkg::word_t'(pc_m), w0, w1);
        check_word("ff_sdo acc", acc_m, w0);
        check_addr("ff_sdo pc", pc_m, w1[`EMU_ADDR_W-1:0]);
        check_word("ff_sdo word1 upper", '0, w1 >> `EMU_ADDR_W);
    endtask

    task automatic run_steps(input int n);
        int pulses;
        pulses   = 0;
        run_mode = 1'b1;
        repeat (n) begin
            @(negedge host_clk);
            pulses += target_step;
        end
        run_mode = 1'b0;
        repeat (2) begin
            @(negedge host_clk);
            pulses += target_step;
        end
        check_pulses("target_step pulses", n, pulses);
        for (int s = 0; s < n; s++) begin
            acc_m = acc_m + mem_m[pc_m];
            pc_m  = emu_pkg::addr_t'((int'(pc_m) + 1) % `EMU_MEM_DEPTH);
        end
    endtask

    task automatic ram_round_trip();
        emu_pkg::word_t w;
        enter_scan();
        ram_scan_reset = 1'b1;
        @(negedge host_clk);
        ram_scan_reset = 1'b0;
        for (int a = 0; a < `EMU_MEM_DEPTH; a++) begin
            w        = random_word();
            mem_m[a] = w;
            ram_dir  = 1'b1;
            ram_sdi  = w;
            ram_scan = 1'b1;
            @(negedge host_clk);
            ram_scan = 1'b0;
        end
        ram_scan_reset = 1'b1;
        @(negedge host_clk);
        ram_scan_reset = 1'b0;
        for (int a = 0; a < `EMU_MEM_DEPTH; a++) begin
            ram_dir  = 1'b0;
            ram_scan = 1'b1;
            @(negedge host_clk);
            ram_scan = 1'b0;
            check_word("ram_sdo", mem_m[a], ram_sdo);
        end
        leave_scan();
    endtask

    task automatic loopback_scan();
        emu_pkg::word_t w0;
        emu_pkg::word_t w1;
        enter_scan();
        scan_chain(1'b0, '0, '0, w0, w1);
        check_word("loopback acc", acc_m, w0);
        check_word("loopback word1", emu_pkg::word_t'(pc_m), w1);
        check_chain();
        leave_scan();
    endtask

    task automatic load_and_run(input emu_pkg::word_t acc_in, input emu_pkg::addr_t pc_in,
                                input int n);
        emu_pkg::word_t w0;
        emu_pkg::word_t w1;
        enter_scan();
        scan_chain(1'b1, acc_in, emu_pkg::word_t'(pc_in), w0, w1);
        check_word("old acc", acc_m, w0);
        check_addr("old pc", pc_m, w1[`EMU_ADDR_W-1:0]);
        acc_m = acc_in;
        pc_m  = pc_in;
        leave_scan();
        run_steps(n);
        enter_scan();
        check_chain();
        leave_scan();
    endtask

    task automatic mode_priority(input int n);
        run_mode  = 1'b1;
        scan_mode = 1'b1;
        repeat (n) begin
            @(negedge host_clk);
            check_bit("target_step", 1'b0, target_step);
            check_bit("idle", 1'b0, idle);
        end
        run_mode  = 1'b0;
        scan_mode = 1'b0;
        @(negedge host_clk);
        check_bit("idle", 1'b1, idle);
    endtask

    // timeout scales with the table, each row gets a fixed overhead.
    initial begin
        longint limit;
        test_row_t r;
        limit = 10;
        for (int i = 0; i < NUM_TESTS; i++) begin
            r = get_row(i);
            limit += 3 * int'(r.steps) + 80;
        end
        #(limit * 40 + 2000);
        $display("timeout: the tests did not finish within %0d ns", limit * 40 + 2000);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        run_mode       = 1'b0;
        scan_mode      = 1'b0;
        ff_scan        = 1'b0;
        ff_dir         = 1'b1;
        ff_sdi         = '0;
        ram_scan_reset = 1'b0;
        ram_scan       = 1'b0;
        ram_dir        = 1'b0;
        ram_sdi        = '0;
        lfsr           = 32'h96cd_c38f;
        acc_m          = '0;
        pc_m           = '0;
        n_checks       = 0;
        n_errors       = 0;
        repeat (2) @(negedge host_clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            row           = get_row(i);
            errs_before   = n_errors;
            checks_before = n_checks;
            case (row.kind)
                K_RESET: begin
                    check_bit("idle", 1'b1, idle);
                    check_bit("target_step", 1'b0, target_step);
                    check_word("ff_sdo", '0, ff_sdo);
                    check_word("ram_sdo", '0, ram_sdo);
                end
                K_RAM: ram_round_trip();
                K_RUN: begin
                    run_steps(int'(row.steps));
                    enter_scan();
                    check_chain();
                    leave_scan();
                end
                K_LOOP: loopback_scan();
                K_LOAD: load_and_run(row.acc, row.pc, int'(row.steps));
                default: mode_priority(int'(row.steps));
            endcase
            st = dut_i.clock_ctrl_i.state;
            $display("test %0d %s done: %0d checks, %0d errors, ctrl %s", i,
                     kind_name(row.kind), n_checks - checks_before,
                     n_errors - errs_before, st.name());
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
